// File: compile.f
+incdir+testbench
rtl/lb_pkg.sv
rtl/rx_multi_counter.sv
rtl/lb_mirror_ram.sv
rtl/led_pwm.sv
rtl/lb_marble_slave.sv
rtl/lb_marble_top.sv
testbench/tb_lb_marble.sv

// File: rtl/lb_marble_slave.sv
`timescale 1ns/10ps
`default_nettype none

module lb_marble_slave (
	input  logic                clk,
	input  logic                arst_n,
	input  lb_pkg::lb_req_t     lb_req,
	output lb_pkg::lb_data_t    data_in,
	input  lb_pkg::cnt_t        rx_count,
	input  logic                led_tick,
	input  logic                xdomain_fault,
	input  logic                tx_mac_done,
	input  logic [1:0]          rx_mac_buf_status,
	output lb_pkg::duty_t       duty1,
	output lb_pkg::duty_t       duty2,
	output logic                led_user_mode,
	output logic                rx_mac_hbank,
	output logic                cfg_d02,
	output logic                mmc_int,
	output logic                allow_mmc_eth_config,
	output logic                zest_pwr_en,
	output logic [3:0]          ext_config
);

	import lb_pkg::*;

	logic do_rd;
	logic local_write;

	assign do_rd = lb_req.strobe & lb_req.rd;
	// Same page decode as the mirror readback
	assign local_write = lb_req.strobe & ~lb_req.rd & (lb_req.addr[23:16] == PAGE_WRITE);

	// ----------------------------------------------------------------------
	// Direct-write control registers
	// ----------------------------------------------------------------------
	misc_cfg_t misc_cfg;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			led_user_mode <= 1'b0;
			duty1 <= '0;
			duty2 <= '0;
			rx_mac_hbank <= 1'b1;
			misc_cfg <= '0;
		end else if (local_write) begin
			case (lb_req.addr[4:0])
				WR_LED_USER: led_user_mode <= lb_req.wdata[0];
				WR_LED1_DF: duty1 <= lb_req.wdata[7:0];
				WR_LED2_DF: duty2 <= lb_req.wdata[7:0];
				WR_HBANK: rx_mac_hbank <= lb_req.wdata[0];
				WR_MISC: misc_cfg <= lb_req.wdata[7:0];
				default: ;
			endcase
		end
	end

	// Misc byte fans out to board pins
	assign cfg_d02 = misc_cfg[0];
	assign mmc_int = misc_cfg[1];
	assign allow_mmc_eth_config = misc_cfg[2];
	assign zest_pwr_en = misc_cfg[3];
	assign ext_config = misc_cfg[7:4];

	// ----------------------------------------------------------------------
	// Status counters and snapshots
	// ----------------------------------------------------------------------
	cnt_t fault_cnt;
	lb_data_t uptime;
	logic tx_mac_done_r;
	logic [1:0] rx_mac_buf_status_r;

	// Expect a burst of faults while the clock trees come up
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			fault_cnt <= '0;
		end else if (xdomain_fault) begin
			fault_cnt <= fault_cnt + 1'b1;
		end
	end

	// Uptime in LED periods
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			uptime <= '0;
		end else if (led_tick) begin
			uptime <= uptime + 1'b1;
		end
	end

	// Pin MAC status into this clock domain before it is read
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			tx_mac_done_r <= 1'b0;
			rx_mac_buf_status_r <= '0;
		end else begin
			tx_mac_done_r <= tx_mac_done;
			rx_mac_buf_status_r <= rx_mac_buf_status;
		end
	end

	// ----------------------------------------------------------------------
	// Mirror memory
	// ----------------------------------------------------------------------
	lb_data_t mirror_out;

	lb_mirror_ram u_lb_mirror_ram (
		.clk     (clk),
		.wr_en   (local_write),
		.wr_addr (lb_req.addr[MIRROR_AW-1:0]),
		.wr_data (lb_req.wdata),
		.rd_addr (lb_req.addr[MIRROR_AW-1:0]),
		.rd_data (mirror_out)
	);

	// ----------------------------------------------------------------------
	// Two-stage read pipeline
	// ----------------------------------------------------------------------
	logic do_rd_r;
	lb_addr_t addr_r;
	lb_data_t status_word;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			do_rd_r <= 1'b0;
		end else begin
			do_rd_r <= do_rd;
		end
	end

	// Stage one, status page word and the address
	always_ff @(posedge clk) begin
		addr_r <= lb_req.addr;
		if (do_rd) begin
			case (lb_req.addr[3:0])
				4'h0: status_word <= ID_WORD_0;
				4'h1: status_word <= ID_WORD_1;
				4'h2: status_word <= ID_WORD_2;
				4'h3: status_word <= ID_WORD_3;
				4'h4: status_word <= {16'h0000, fault_cnt};
				4'h5: status_word <= uptime;
				4'h6: status_word <= {30'd0, rx_mac_buf_status_r};
				4'h7: status_word <= {31'd0, tx_mac_done_r};
				default: status_word <= '0;
			endcase
		end
	end

	// Stage two, counter and mirror ports are ready by now
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			data_in <= '0;
		end else if (do_rd_r) begin
			if (addr_r[23:4] == PAGE_STATUS) begin
				data_in <= status_word;
			end else if (addr_r[23:12] == PAGE_RXCNT) begin
				data_in <= {16'h0000, rx_count};
			end else if (addr_r[23:16] == PAGE_WRITE) begin
				data_in <= mirror_out;
			end else begin
				data_in <= LB_UNMAPPED;
			end
		end
	end

	// ----------------------------------------------------------------------
	// Checks
	// ----------------------------------------------------------------------
	a_strobe_known: assert property (
		@(posedge clk) disable iff (!arst_n)
		!$isunknown(lb_req.strobe)
	) else $error("lb_req.strobe unknown");

	// Reply word only moves one edge after a stage-two read
	a_data_in_hold: assert property (
		@(posedge clk) disable iff (!arst_n)
		!$stable(data_in) |-> $past(do_rd_r)
	) else $error("data_in changed without a read in stage two");

endmodule

`default_nettype wire

// File: rtl/lb_marble_top.sv
`timescale 1ns/10ps
`default_nettype none

module lb_marble_top (
	input  logic                clk,
	input  logic                arst_n,
	input  lb_pkg::lb_req_t     lb_req,
	output lb_pkg::lb_data_t    data_in,
	input  lb_pkg::rx_event_t   rx_event,
	input  logic                xdomain_fault,
	input  logic                tx_mac_done,
	input  logic [1:0]          rx_mac_buf_status,
	output logic                led1,
	output logic                led2,
	output logic                led_user_mode,
	output logic                rx_mac_hbank,
	output logic                cfg_d02,
	output logic                mmc_int,
	output logic                allow_mmc_eth_config,
	output logic                zest_pwr_en,
	output logic [3:0]          ext_config
);

	import lb_pkg::*;

	cnt_t rx_count;
	duty_t duty1;
	duty_t duty2;
	logic led_tick;

	lb_marble_slave u_lb_marble_slave (
		.clk                  (clk),
		.arst_n               (arst_n),
		.lb_req               (lb_req),
		.data_in              (data_in),
		.rx_count             (rx_count),
		.led_tick             (led_tick),
		.xdomain_fault        (xdomain_fault),
		.tx_mac_done          (tx_mac_done),
		.rx_mac_buf_status    (rx_mac_buf_status),
		.duty1                (duty1),
		.duty2                (duty2),
		.led_user_mode        (led_user_mode),
		.rx_mac_hbank         (rx_mac_hbank),
		.cfg_d02              (cfg_d02),
		.mmc_int              (mmc_int),
		.allow_mmc_eth_config (allow_mmc_eth_config),
		.zest_pwr_en          (zest_pwr_en),
		.ext_config           (ext_config)
	);

	// Counter page index comes straight off the bus address
	rx_multi_counter u_rx_multi_counter (
		.clk       (clk),
		.arst_n    (arst_n),
		.rx_event  (rx_event),
		.read_addr (lb_req.addr[3:0]),
		.read_data (rx_count)
	);

	led_pwm u_led_pwm (
		.clk      (clk),
		.arst_n   (arst_n),
		.duty1    (duty1),
		.duty2    (duty2),
		.led1     (led1),
		.led2     (led2),
		.led_tick (led_tick)
	);

endmodule

`default_nettype wire

// File: rtl/lb_mirror_ram.sv
`timescale 1ns/10ps
`default_nettype none

module lb_mirror_ram (
	input  logic                            clk,
	input  logic                            wr_en,
	input  logic [lb_pkg::MIRROR_AW-1:0]    wr_addr,
	input  lb_pkg::lb_data_t                wr_data,
	input  logic [lb_pkg::MIRROR_AW-1:0]    rd_addr,
	output lb_pkg::lb_data_t                rd_data
);

	import lb_pkg::*;

	// Plain storage, nothing to clear
	lb_data_t mem [2**MIRROR_AW];

	// Write port
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Read port, one cycle of latency
	// old data on a same-address collision
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// File: rtl/lb_pkg.sv
`default_nettype none

package lb_pkg;

	// ----------------------------------------------------------------------
	// Widths that carry a meaning
	// ----------------------------------------------------------------------
	localparam int LED_CW = 10;
	localparam int MIRROR_AW = 5;

	typedef logic [23:0] lb_addr_t;
	typedef logic [31:0] lb_data_t;
	typedef logic [3:0] rx_cat_t;
	typedef logic [15:0] cnt_t;
	typedef logic [7:0] duty_t;
	typedef logic [LED_CW-1:0] led_cnt_t;
	typedef logic [7:0] misc_cfg_t;

	// One local-bus request, as seen in a single cycle
	typedef struct packed {
		logic strobe;
		logic rd;
		lb_addr_t addr;
		lb_data_t wdata;
	} lb_req_t;

	// One receive event from the packet classifier
	typedef struct packed {
		logic valid;
		rx_cat_t cat;
	} rx_event_t;

	// ----------------------------------------------------------------------
	// Address map
	// ----------------------------------------------------------------------
	localparam lb_data_t ID_WORD_0 = "Hell";
	localparam lb_data_t ID_WORD_1 = "o wo";
	localparam lb_data_t ID_WORD_2 = "rld!";
	localparam lb_data_t ID_WORD_3 = "(::)";
	localparam lb_data_t LB_UNMAPPED = 32'hdeadbeef;

	// Page codes, compared against addr[23:4], addr[23:12] and addr[23:16]
	localparam logic [19:0] PAGE_STATUS = 20'h00000;
	localparam logic [11:0] PAGE_RXCNT = 12'h041;
	localparam logic [7:0] PAGE_WRITE = 8'h05;

	// Direct-write register offsets inside the write page
	localparam logic [4:0] WR_LED_USER = 5'd1;
	localparam logic [4:0] WR_LED1_DF = 5'd2;
	localparam logic [4:0] WR_LED2_DF = 5'd3;
	localparam logic [4:0] WR_HBANK = 5'd5;
	localparam logic [4:0] WR_MISC = 5'd8;

endpackage

`default_nettype wire

// File: rtl/led_pwm.sv
`timescale 1ns/10ps
`default_nettype none

module led_pwm (
	input  logic            clk,
	input  logic            arst_n,
	input  lb_pkg::duty_t   duty1,
	input  lb_pkg::duty_t   duty2,
	output logic            led1,
	output logic            led2,
	output logic            led_tick
);

	import lb_pkg::*;

	led_cnt_t led_cc;

	// Free-running period counter, carry out is the tick
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			led_cc <= '0;
			led_tick <= 1'b0;
		end else begin
			{led_tick, led_cc} <= {1'b0, led_cc} + 1'b1;
		end
	end

	// Duty factor scaled by 4 spans the full period
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			led1 <= 1'b0;
			led2 <= 1'b0;
		end else begin
			led1 <= led_cc < {duty1, 2'b00};
			led2 <= led_cc < {duty2, 2'b00};
		end
	end

endmodule

`default_nettype wire

// File: rtl/rx_multi_counter.sv
`timescale 1ns/10ps
`default_nettype none

module rx_multi_counter (
	input  logic                clk,
	input  logic                arst_n,
	input  lb_pkg::rx_event_t   rx_event,
	input  lb_pkg::rx_cat_t     read_addr,
	output lb_pkg::cnt_t        read_data
);

	import lb_pkg::*;

	// One wrapping counter per receive category
	cnt_t counters [2**$bits(rx_cat_t)];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 2**$bits(rx_cat_t); i++) begin
				counters[i] <= '0;
			end
		end else if (rx_event.valid) begin
			counters[rx_event.cat] <= counters[rx_event.cat] + 1'b1;
		end
	end

	// Registered read port on the bus address
	always_ff @(posedge clk) begin
		read_data <= counters[read_addr];
	end

	// ----------------------------------------------------------------------
	// Checks
	// ----------------------------------------------------------------------

	// An unknown category would silently bump no counter, or the wrong one
	a_cat_known: assert property (
		@(posedge clk) disable iff (!arst_n)
		rx_event.valid |-> !$isunknown(rx_event.cat)
	) else $error("rx_event.cat unknown while valid");

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_lb_marble \
	-f compile.f -o tb_lb_marble &&
./obj_dir/tb_lb_marble | tee /dev/stderr | grep -q "All checks passed" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// File: testbench/tb_lb_ref.svh
`ifndef TB_LB_REF_SVH
`define TB_LB_REF_SVH
`default_nettype none

// Shadow of everything the bus can read back
lb_data_t sh_mirror [32];
cnt_t sh_rx_cnt [16];
cnt_t sh_fault;
logic sh_led_user;
logic sh_hbank;
duty_t sh_duty1;
duty_t sh_duty2;
misc_cfg_t sh_misc;
logic [1:0] sh_buf_status;
logic sh_tx_done;

// State right after reset, mirror stays unknown
function automatic void shadow_reset();
	for (int i = 0; i < 16; i++) begin
		sh_rx_cnt[i] = '0;
	end
	sh_fault = '0;
	sh_led_user = 1'b0;
	sh_hbank = 1'b1;
	sh_duty1 = '0;
	sh_duty2 = '0;
	sh_misc = '0;
	sh_buf_status = '0;
	sh_tx_done = 1'b0;
endfunction

// Every write-page write lands in the mirror, some also in a control register
function automatic void shadow_write(lb_addr_t addr, lb_data_t data);
	if (addr[23:16] == 8'h05) begin
		sh_mirror[addr[4:0]] = data;
		case (addr[4:0])
			5'd1: sh_led_user = data[0];
			5'd2: sh_duty1 = data[7:0];
			5'd3: sh_duty2 = data[7:0];
			5'd5: sh_hbank = data[0];
			5'd8: sh_misc = data[7:0];
			default: ;
		endcase
	end
endfunction

function automatic lb_data_t expected_read(lb_addr_t addr);
	lb_data_t word;
	if (addr[23:4] == 20'h00000) begin
		case (addr[3:0])
			// ID string, four ASCII characters per word
			4'h0: word = 32'h48656c6c;
			4'h1: word = 32'h6f20776f;
			4'h2: word = 32'h726c6421;
			4'h3: word = 32'h283a3a29;
			4'h4: word = {16'h0000, sh_fault};
			// Uptime follows the LED tick, not predicted here
			4'h5: word = 'x;
			4'h6: word = {30'd0, sh_buf_status};
			4'h7: word = {31'd0, sh_tx_done};
			default: word = '0;
		endcase
	end else if (addr[23:12] == 12'h041) begin
		word = {16'h0000, sh_rx_cnt[addr[3:0]]};
	end else if (addr[23:16] == 8'h05) begin
		word = sh_mirror[addr[4:0]];
	end else begin
		word = 32'hdeadbeef;
	end
	return word;
endfunction

`default_nettype wire
`endif

// File: testbench/tb_lb_marble.sv
`timescale 1ns/10ps
`default_nettype none

module tb_lb_marble;

	import lb_pkg::*;

	localparam int MAX_CYCLES = 6000;

	logic clk;
	logic arst_n;
	lb_req_t lb_req;
	lb_data_t data_in;
	rx_event_t rx_event;
	logic xdomain_fault;
	logic tx_mac_done;
	logic [1:0] rx_mac_buf_status;
	logic led1;
	logic led2;
	logic led_user_mode;
	logic rx_mac_hbank;
	logic cfg_d02;
	logic mmc_int;
	logic allow_mmc_eth_config;
	logic zest_pwr_en;
	logic [3:0] ext_config;

	integer seed = 27;
	logic [31:0] rnd;
	int cycle_cnt = 0;
	int check_count = 0;
	int error_count = 0;
	int test_checks = 0;
	int test_errors = 0;

	// Reads in flight with the oldest first
	lb_addr_t rd_addr_q [$];
	lb_data_t rd_exp_q [$];
	int rd_due_q [$];

	`include "tb_lb_ref.svh"

	lb_marble_top u_lb_marble_top (
		.clk                  (clk),
		.arst_n               (arst_n),
		.lb_req               (lb_req),
		.data_in              (data_in),
		.rx_event             (rx_event),
		.xdomain_fault        (xdomain_fault),
		.tx_mac_done          (tx_mac_done),
		.rx_mac_buf_status    (rx_mac_buf_status),
		.led1                 (led1),
		.led2                 (led2),
		.led_user_mode        (led_user_mode),
		.rx_mac_hbank         (rx_mac_hbank),
		.cfg_d02              (cfg_d02),
		.mmc_int              (mmc_int),
		.allow_mmc_eth_config (allow_mmc_eth_config),
		.zest_pwr_en          (zest_pwr_en),
		.ext_config           (ext_config)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ----------------------------------------------------------------------
	// Watchdog and read compare
	// ----------------------------------------------------------------------
	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("Run timed out at cycle %0d", cycle_cnt);
			$display("Checks failed");
			$finish;
		end
	end

	// data_in is settled by the falling edge after stage two
	always @(negedge clk) begin
		if (rd_due_q.size() != 0 && rd_due_q[0] <= cycle_cnt) begin
			check_count++;
			if (data_in !== rd_exp_q[0]) begin
				error_count++;
				$display("ERROR data_in at addr %h: got %h expected %h",
					rd_addr_q[0], data_in, rd_exp_q[0]);
			end
			void'(rd_addr_q.pop_front());
			void'(rd_exp_q.pop_front());
			void'(rd_due_q.pop_front());
		end
	end

	// ----------------------------------------------------------------------
	// Bus and check helpers
	// ----------------------------------------------------------------------
	function automatic lb_addr_t status_addr(logic [3:0] off);
		return {20'h00000, off};
	endfunction

	function automatic lb_addr_t write_addr(logic [4:0] off);
		return {8'h05, 11'd0, off};
	endfunction

	function automatic bit in_any_page(lb_addr_t a);
		return a[23:4] == 20'h00000 || a[23:12] == 12'h041 || a[23:16] == 8'h05;
	endfunction

	task automatic bus_read(input lb_addr_t addr);
		@(negedge clk);
		lb_req = '{strobe: 1'b1, rd: 1'b1, addr: addr, wdata: '0};
		rd_addr_q.push_back(addr);
		rd_exp_q.push_back(expected_read(addr));
		rd_due_q.push_back(cycle_cnt + 2);
	endtask

	task automatic bus_write(input lb_addr_t addr, input lb_data_t data);
		@(negedge clk);
		lb_req = '{strobe: 1'b1, rd: 1'b0, addr: addr, wdata: data};
		shadow_write(addr, data);
	endtask

	task automatic bus_idle();
		@(negedge clk);
		lb_req.strobe = 1'b0;
		lb_req.rd = 1'b0;
	endtask

	task automatic wait_reads_done();
		while (rd_due_q.size() != 0) begin
			@(negedge clk);
		end
	endtask

	task automatic check_value(input string name, input lb_data_t got, input lb_data_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("ERROR %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_controls();
		check_value("led_user_mode", {31'd0, led_user_mode}, {31'd0, sh_led_user});
		check_value("rx_mac_hbank", {31'd0, rx_mac_hbank}, {31'd0, sh_hbank});
		check_value("cfg_d02", {31'd0, cfg_d02}, {31'd0, sh_misc[0]});
		check_value("mmc_int", {31'd0, mmc_int}, {31'd0, sh_misc[1]});
		check_value("allow_mmc_eth_config", {31'd0, allow_mmc_eth_config},
			{31'd0, sh_misc[2]});
		check_value("zest_pwr_en", {31'd0, zest_pwr_en}, {31'd0, sh_misc[3]});
		check_value("ext_config", {28'd0, ext_config}, {28'd0, sh_misc[7:4]});
	endtask

	task automatic end_test(input string name);
		$display("%s: %0d checks, %0d errors", name, check_count - test_checks,
			error_count - test_errors);
		test_checks = check_count;
		test_errors = error_count;
	endtask

	// ----------------------------------------------------------------------
	// Tests
	// ----------------------------------------------------------------------
	task automatic test_control();
		check_controls();
		check_value("data_in", data_in, 32'd0);
		check_value("led1", {31'd0, led1}, 32'd0);
		check_value("led2", {31'd0, led2}, 32'd0);
		for (int k = 0; k < 4; k++) begin
			rnd = $random(seed);
			bus_write(write_addr(5'd8), {24'd0, rnd[7:0]});
			bus_write(write_addr(5'd1), {31'd0, rnd[8]});
			bus_write(write_addr(5'd5), {31'd0, rnd[9]});
			bus_idle();
			check_controls();
		end
		end_test("control outputs");
	endtask

	task automatic test_id_unmapped();
		lb_addr_t a;
		int n;
		// ID and blank offsets go out back to back
		for (int i = 0; i < 16; i++) begin
			if (i < 4 || i > 7) begin
				bus_read(status_addr(i[3:0]));
			end
		end
		n = 0;
		while (n < 16) begin
			rnd = $random(seed);
			a = rnd[23:0];
			if (!in_any_page(a)) begin
				bus_read(a);
				bus_read(status_addr({2'b00, rnd[25:24]}));
				n++;
			end
		end
		bus_idle();
		wait_reads_done();
		end_test("id and unmapped");
	endtask

	task automatic test_mirror();
		int order [32];
		int j;
		int t;
		for (int i = 0; i < 32; i++) begin
			rnd = $random(seed);
			bus_write(write_addr(i[4:0]), rnd);
			order[i] = i;
		end
		// Shuffle the readback order
		for (int i = 31; i > 0; i--) begin
			rnd = $random(seed);
			j = int'(rnd[15:0]) % (i + 1);
			t = order[i];
			order[i] = order[j];
			order[j] = t;
		end
		for (int i = 0; i < 32; i++) begin
			bus_read(write_addr(order[i][4:0]));
		end
		bus_idle();
		wait_reads_done();
		end_test("mirror memory");
	endtask

	task automatic test_counters();
		for (int k = 0; k < 300; k++) begin
			@(negedge clk);
			rnd = $random(seed);
			rx_event.valid = rnd[0] | rnd[1];
			rx_event.cat = rnd[7:4];
			if (rx_event.valid) begin
				sh_rx_cnt[rnd[7:4]] = sh_rx_cnt[rnd[7:4]] + 16'd1;
			end
		end
		@(negedge clk);
		rx_event.valid = 1'b0;
		for (int i = 0; i < 16; i++) begin
			bus_read({12'h041, 8'h00, i[3:0]});
		end
		bus_idle();
		wait_reads_done();
		end_test("packet counters");
	endtask

	task automatic test_fault_status();
		int pulses;
		rnd = $random(seed);
		pulses = 20 + int'(rnd[7:3]);
		rx_mac_buf_status = rnd[1:0];
		tx_mac_done = rnd[2];
		sh_buf_status = rnd[1:0];
		sh_tx_done = rnd[2];
		for (int k = 0; k < pulses; k++) begin
			@(negedge clk);
			xdomain_fault = 1'b1;
			sh_fault = sh_fault + 16'd1;
			@(negedge clk);
			xdomain_fault = 1'b0;
		end
		bus_read(status_addr(4'h4));
		bus_read(status_addr(4'h6));
		bus_read(status_addr(4'h7));
		bus_idle();
		wait_reads_done();
		end_test("fault counter and mac status");
	endtask

	task automatic test_led_duty();
		int high1;
		int high2;
		for (int r = 0; r < 2; r++) begin
			rnd = $random(seed);
			bus_write(write_addr(5'd2), {24'd0, rnd[7:0]});
			bus_write(write_addr(5'd3), {24'd0, rnd[15:8]});
			bus_idle();
			repeat (4) @(negedge clk);
			high1 = 0;
			high2 = 0;
			// One full LED period
			repeat (1024) begin
				@(negedge clk);
				high1 += int'(led1);
				high2 += int'(led2);
			end
			check_value("led1 high cycles", high1, 4 * int'(sh_duty1));
			check_value("led2 high cycles", high2, 4 * int'(sh_duty2));
		end
		end_test("led duty");
	endtask

	initial begin
		lb_req = '0;
		rx_event = '0;
		xdomain_fault = 1'b0;
		tx_mac_done = 1'b0;
		rx_mac_buf_status = '0;
		shadow_reset();
		arst_n = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		test_control();
		test_id_unmapped();
		test_mirror();
		test_counters();
		test_fault_status();
		test_led_duty();
		$display("Total: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0 && check_count > 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
